//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_core_pkg::decode_t     dec_i,

    // Writeback result
    output rv_core_pkg::word_t       wdata_o,

    // Redirect toward fetch
    output logic                     jump_o,
    output rv_core_pkg::word_t       jump_target_o,

    // Store toward the store port
    output logic                     store_o,
    output rv_core_pkg::store_req_t  store_req_o
);
    import rv_core_pkg::*;

    word_t base_sum;

    // Base plus immediate serves jal, jalr and sw
    assign base_sum = dec_i.operand1 + dec_i.imm;

    always_comb begin
        case (dec_i.alu_op)
            op_add:          wdata_o = dec_i.operand1 + dec_i.operand2;
            op_jal, op_jalr: wdata_o = dec_i.link;
            default:         wdata_o = '0;
        endcase
    end

    assign jump_o = (dec_i.alu_op == op_jal) | (dec_i.alu_op == op_jalr);

    always_comb begin
        case (dec_i.alu_op)
            op_jal:  jump_target_o = base_sum;
            // jalr drops bit 0 of the target
            op_jalr: jump_target_o = {base_sum[31:1], 1'b0};
            default: jump_target_o = '0;
        endcase
    end

    assign store_o          = dec_i.store;
    assign store_req_o.addr = (dec_i.alu_op == op_store) ? base_sum : '0;
    assign store_req_o.data = dec_i.store_data;

endmodule

`default_nettype wire

//--- inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module inst_decode (
    // Current instruction and its address
    input  rv_core_pkg::word_t      pc_i,
    input  rv_core_pkg::inst_t      inst_i,

    // Register file read data
    input  rv_core_pkg::word_t      data1_i,
    input  rv_core_pkg::word_t      data2_i,

    // Register file read addresses
    output rv_core_pkg::reg_addr_t  raddr1_o,
    output rv_core_pkg::reg_addr_t  raddr2_o,

    output rv_core_pkg::decode_t    dec_o
);
    import rv_core_pkg::*;

    logic [11:0] funct12;
    reg_addr_t   rs2;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;

    word_t imm_i;
    word_t imm_s;
    word_t imm_u;
    word_t imm_j;
    word_t imm;

    logic inst_addi;
    logic inst_jalr;
    logic inst_auipc;
    logic inst_lui;
    logic inst_jal;
    logic inst_sw;
    logic inst_ebreak;
    logic inst_unknown;
    logic rs1_used;

    // Field split
    assign funct12 = inst_i[31:20];
    assign rs2     = inst_i[24:20];
    assign rs1     = inst_i[19:15];
    assign funct3  = inst_i[14:12];
    assign rd      = inst_i[11:7];
    assign opcode  = inst_i[6:0];

    // Immediates sign extend from bit 31
    assign imm_i = {{21{inst_i[31]}}, inst_i[30:20]};
    assign imm_s = {{21{inst_i[31]}}, inst_i[30:25], inst_i[11:7]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // Classification
    assign inst_addi   = (opcode == `OPCODE_ADDI) & (funct3 == `FUNCT3_ADDI);
    assign inst_jalr   = (opcode == `OPCODE_JALR) & (funct3 == `FUNCT3_JALR);
    assign inst_auipc  = (opcode == `OPCODE_AUIPC);
    assign inst_lui    = (opcode == `OPCODE_LUI);
    assign inst_jal    = (opcode == `OPCODE_JAL);
    assign inst_sw     = (opcode == `OPCODE_SW) & (funct3 == `FUNCT3_SW);
    assign inst_ebreak = (opcode == `OPCODE_EBREAK) & (funct3 == `FUNCT3_EBREAK) &
                         (funct12 == `FUNCT12_EBREAK);

    // Anything outside the supported subset
    assign inst_unknown = ~(inst_addi | inst_jalr | inst_auipc | inst_lui |
                            inst_jal | inst_sw | inst_ebreak);

    assign imm = (inst_addi | inst_jalr)  ? imm_i :
                 (inst_auipc | inst_lui)  ? imm_u :
                 inst_jal                 ? imm_j :
                 inst_sw                  ? imm_s : '0;

    // Register reads
    assign rs1_used = inst_addi | inst_jalr | inst_sw;
    assign raddr1_o = rs1_used ? rs1 : '0;
    // rs2 only carries store data
    assign raddr2_o = inst_sw ? rs2 : '0;

    assign dec_o.alu_op = (inst_addi | inst_auipc | inst_lui) ? op_add   :
                          inst_jal                            ? op_jal   :
                          inst_jalr                           ? op_jalr  :
                          inst_sw                             ? op_store : op_nop;

    // jal also takes the pc as base so the ALU forms its target the same way
    assign dec_o.operand1 = rs1_used               ? data1_i :
                            (inst_auipc | inst_jal) ? pc_i    : '0;
    assign dec_o.operand2 = imm;
    assign dec_o.imm      = imm;
    assign dec_o.link     = pc_i + 32'd4;

    // Writeback
    assign dec_o.we    = inst_addi | inst_auipc | inst_lui | inst_jal | inst_jalr;
    assign dec_o.waddr = dec_o.we ? rd : '0;

    assign dec_o.store      = inst_sw;
    assign dec_o.store_data = inst_sw ? data2_i : '0;

    assign dec_o.ebreak  = inst_ebreak;
    assign dec_o.unknown = inst_unknown;

endmodule

`default_nettype wire

//--- inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module inst_fetch (
    input  wire                   clk_i,
    input  wire                   arst_n_i,

    // Instruction memory side
    output rv_core_pkg::word_t    imem_addr_o,
    output rv_core_pkg::word_t    pc_o,

    // Redirect from the ALU
    input  wire                   jump_i,
    input  rv_core_pkg::word_t    jump_target_i,

    // Stall and stop conditions
    input  wire                   store_i,
    input  wire                   no_credit_i,
    input  wire                   ebreak_i,
    input  wire                   unknown_i,

    output logic                  advance_o,
    output logic                  halt_o,
    output logic                  illegal_o
);
    import rv_core_pkg::*;

    word_t       pc;
    word_t       pc_next;
    core_state_e state;
    logic        store_stall;

    // A sw that finds the sink full waits in place
    assign store_stall = store_i & no_credit_i;

    // ebreak and unknown encodings retire nothing
    assign advance_o = (state == st_run) & ~store_stall & ~ebreak_i & ~unknown_i;

    assign pc_next = jump_i ? jump_target_i : pc + 32'd4;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc    <= `RESET_PC;
            state <= st_run;
        end else begin
            if (advance_o) begin
                pc <= pc_next;
            end
            if (state == st_run) begin
                if (ebreak_i) begin
                    state <= st_halted;
                end else if (unknown_i) begin
                    state <= st_illegal;
                end
            end
        end
    end

    assign imem_addr_o = pc;
    assign pc_o        = pc;

    // Sticky until reset
    assign halt_o    = (state == st_halted);
    assign illegal_o = (state == st_illegal);

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                     clk_i,
    input  wire                     arst_n_i,

    // Read ports
    input  rv_core_pkg::reg_addr_t  raddr1_i,
    input  rv_core_pkg::reg_addr_t  raddr2_i,
    output rv_core_pkg::word_t      rdata1_o,
    output rv_core_pkg::word_t      rdata2_o,

    // Write port
    input  wire                     we_i,
    input  rv_core_pkg::reg_addr_t  waddr_i,
    input  rv_core_pkg::word_t      wdata_i
);
    import rv_core_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous reads with x0 reading as zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_rv_core -f rv_core.f -o tb_rv_core
out=$(./obj_dir/tb_rv_core)
echo "$out"
if echo "$out" | grep -q "all tests passed"; then
    exit 0
fi
exit 1

//--- rv_core.f
+incdir+.
rv_core_pkg.sv
inst_fetch.sv
inst_decode.sv
regfile.sv
alu.sv
store_port.sv
rv_core.sv
tb_rv_core.sv

//--- rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                      clk_i,
    input  wire                      arst_n_i,

    // Instruction memory
    output rv_core_pkg::word_t       imem_addr_o,
    input  rv_core_pkg::inst_t       imem_data_i,

    // Store channel
    output logic                     store_valid_o,
    output rv_core_pkg::store_req_t  store_req_o,
    input  wire                      store_credit_i,

    // Program end
    output logic                     halt_o,
    output logic                     illegal_o
);
    import rv_core_pkg::*;

    word_t      pc;
    reg_addr_t  raddr1;
    reg_addr_t  raddr2;
    word_t      rdata1;
    word_t      rdata2;
    decode_t    dec;
    word_t      wdata;
    logic       jump;
    word_t      jump_target;
    logic       store;
    store_req_t store_req;
    logic       no_credit;
    logic       advance;

    inst_fetch inst_fetch_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .imem_addr_o   (imem_addr_o),
        .pc_o          (pc),
        .jump_i        (jump),
        .jump_target_i (jump_target),
        .store_i       (store),
        .no_credit_i   (no_credit),
        .ebreak_i      (dec.ebreak),
        .unknown_i     (dec.unknown),
        .advance_o     (advance),
        .halt_o        (halt_o),
        .illegal_o     (illegal_o)
    );

    inst_decode inst_decode_i (
        .pc_i     (pc),
        .inst_i   (imem_data_i),
        .data1_i  (rdata1),
        .data2_i  (rdata2),
        .raddr1_o (raddr1),
        .raddr2_o (raddr2),
        .dec_o    (dec)
    );

    // Writes retire only with the instruction
    regfile regfile_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (dec.we & advance),
        .waddr_i  (dec.waddr),
        .wdata_i  (wdata)
    );

    alu alu_i (
        .dec_i         (dec),
        .wdata_o       (wdata),
        .jump_o        (jump),
        .jump_target_o (jump_target),
        .store_o       (store),
        .store_req_o   (store_req)
    );

    store_port store_port_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .store_i        (store),
        .advance_i      (advance),
        .store_req_i    (store_req),
        .no_credit_o    (no_credit),
        .store_credit_i (store_credit_i),
        .store_valid_o  (store_valid_o),
        .store_req_o    (store_req_o)
    );

endmodule

`default_nettype wire

//--- rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Address of the first fetch after reset
`define RESET_PC        32'h0000_0000

// Requests the data sink can hold before returning a credit
`define STORE_CREDITS   2

// Major opcodes
`define OPCODE_ADDI     7'b0010011
`define OPCODE_JALR     7'b1100111
`define OPCODE_AUIPC    7'b0010111
`define OPCODE_LUI      7'b0110111
`define OPCODE_JAL      7'b1101111
`define OPCODE_SW       7'b0100011
`define OPCODE_EBREAK   7'b1110011

// Minor opcodes
`define FUNCT3_ADDI     3'b000
`define FUNCT3_JALR     3'b000
`define FUNCT3_SW       3'b010
`define FUNCT3_EBREAK   3'b000

// ebreak is told apart from ecall by the upper twelve bits
`define FUNCT12_EBREAK  12'h001

`endif

//--- rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Register index
    typedef logic [4:0] reg_addr_t;

    // Raw instruction word
    typedef logic [31:0] inst_t;

    // Operation handed from the decoder to the ALU
    typedef enum logic [2:0] {
        op_nop,
        op_add,
        op_jal,
        op_jalr,
        op_store
    } alu_op_e;

    // Fetch unit state
    typedef enum logic [1:0] {
        st_run,
        st_halted,
        st_illegal
    } core_state_e;

    // Everything the ALU and the control path need from one instruction
    typedef struct packed {
        alu_op_e   alu_op;
        word_t     operand1;
        word_t     operand2;
        word_t     imm;
        word_t     link;
        logic      we;
        reg_addr_t waddr;
        logic      store;
        word_t     store_data;
        logic      ebreak;
        logic      unknown;
    } decode_t;

    // One word write toward the data sink
    typedef struct packed {
        word_t addr;
        word_t data;
    } store_req_t;

endpackage

`default_nettype wire

//--- store_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module store_port (
    input  wire                      clk_i,
    input  wire                      arst_n_i,

    // From the ALU and fetch
    input  wire                      store_i,
    input  wire                      advance_i,
    input  rv_core_pkg::store_req_t  store_req_i,

    // Stall toward fetch
    output logic                     no_credit_o,

    // Data sink side
    input  wire                      store_credit_i,
    output logic                     store_valid_o,
    output rv_core_pkg::store_req_t  store_req_o
);
    import rv_core_pkg::*;

    localparam int CNT_W = $clog2(`STORE_CREDITS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`STORE_CREDITS);

    logic [CNT_W-1:0] credit_cnt;
    logic [CNT_W-1:0] credit_next;
    logic             issue;

    // Fetch only advances a sw when a credit is available
    assign issue = store_i & advance_i;

    always_comb begin
        credit_next = credit_cnt;
        if (issue && !store_credit_i) begin
            credit_next = credit_cnt - CNT_W'(1);
        end else if (!issue && store_credit_i && (credit_cnt != CNT_MAX)) begin
            // Extra credits beyond the sink depth are dropped
            credit_next = credit_cnt + CNT_W'(1);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt    <= CNT_MAX;
            store_valid_o <= 1'b0;
        end else begin
            credit_cnt    <= credit_next;
            store_valid_o <= issue;
        end
    end

    // Payload register qualified by store_valid_o
    always_ff @(posedge clk_i) begin
        if (issue) begin
            store_req_o <= store_req_i;
        end
    end

    assign no_credit_o = (credit_cnt == '0);

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int TIMEOUT_CYCLES = 300;

    logic       clk = 1'b0;
    logic       arst_n = 1'b0;
    word_t      imem_addr;
    inst_t      imem_data;
    logic       store_valid;
    store_req_t store_req;
    logic       store_credit = 1'b0;
    logic       halt;
    logic       illegal;

    inst_t      imem [256];
    inst_t      prog_q [$];
    store_req_t got_q [$];
    store_req_t exp_q [$];
    logic       hold_credits = 1'b0;
    int         pending = 0;
    int         error_count = 0;
    int         check_count = 0;

    rv_core rv_core_i (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .store_valid_o  (store_valid),
        .store_req_o    (store_req),
        .store_credit_i (store_credit),
        .halt_o         (halt),
        .illegal_o      (illegal)
    );

    always #10 clk = ~clk;

    // Word addressed, upper address bits ignored
    assign imem_data = imem[imem_addr[9:2]];

    // One credit back per finished request unless credits are held back
    always @(negedge clk) begin
        if (!arst_n) begin
            got_q.delete();
            pending = 0;
            store_credit <= 1'b0;
        end else begin
            if (store_valid) begin
                got_q.push_back(store_req);
                pending++;
            end
            if (pending > 0 && !hold_credits) begin
                store_credit <= 1'b1;
                pending--;
            end else begin
                store_credit <= 1'b0;
            end
        end
    end

    function automatic inst_t enc_addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, `FUNCT3_ADDI, rd, `OPCODE_ADDI};
    endfunction

    function automatic inst_t enc_lui(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, `OPCODE_LUI};
    endfunction

    function automatic inst_t enc_auipc(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, `OPCODE_AUIPC};
    endfunction

    function automatic inst_t enc_jal(reg_addr_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPCODE_JAL};
    endfunction

    function automatic inst_t enc_jalr(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, `FUNCT3_JALR, rd, `OPCODE_JALR};
    endfunction

    function automatic inst_t enc_sw(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, `FUNCT3_SW, imm[4:0], `OPCODE_SW};
    endfunction

    function automatic inst_t enc_ebreak();
        return {`FUNCT12_EBREAK, 5'd0, `FUNCT3_EBREAK, 5'd0, `OPCODE_EBREAK};
    endfunction

    function automatic word_t sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_store(input string name, input store_req_t got, input store_req_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error %s: got addr %h data %h, expected addr %h data %h",
                     name, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        error_count++;
        $display("Timed out while waiting for %s", what);
        $display("checks run %0d, errors %0d", check_count, error_count);
        $display("tests failed");
        $finish;
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        store_req_t req;
        req.addr = addr;
        req.data = data;
        exp_q.push_back(req);
    endtask

    // Unused words decode as illegal and carry their own address
    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog_q.size()) ? prog_q[i] : {i[24:0], 7'h7f};
        end
    endtask

    task automatic reset_dut(input logic hold);
        exp_q.delete();
        hold_credits = hold;
        arst_n = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
        end
        check_word("reset imem_addr_o", imem_addr, `RESET_PC);
        check_bit("reset store_valid_o", store_valid, 1'b0);
        check_bit("reset halt_o", halt, 1'b0);
        check_bit("reset illegal_o", illegal, 1'b0);
        arst_n = 1'b1;
    endtask

    task automatic wait_stores(input int n);
        int cycles;
        cycles = 0;
        while (got_q.size() < n && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (got_q.size() < n) begin
            abort_on_timeout($sformatf("%0d stores", n));
        end
    endtask

    task automatic wait_stop();
        int cycles;
        cycles = 0;
        while (!(halt || illegal) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!(halt || illegal)) begin
            abort_on_timeout("halt_o or illegal_o");
        end
    endtask

    // Window in which a stray store would show up
    task automatic settle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    // The pc stays on the instruction that stopped the core
    task automatic finish_and_compare(input string name, input logic exp_halt,
                                      input word_t exp_stop_pc);
        wait_stop();
        settle(8);
        check_bit({name, " halt_o"}, halt, exp_halt);
        check_bit({name, " illegal_o"}, illegal, ~exp_halt);
        check_word({name, " imem_addr_o"}, imem_addr, exp_stop_pc);
        check_word({name, " store count"}, word_t'(got_q.size()), word_t'(exp_q.size()));
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_store($sformatf("%s store %0d", name, i), got_q[i], exp_q[i]);
        end
    endtask

    task automatic test_arith();
        word_t x1;
        word_t x2;
        word_t x3;
        word_t x4;
        prog_q.delete();
        prog_q.push_back(enc_addi(5'd1, 5'd0, 12'h123));
        prog_q.push_back(enc_lui(5'd2, 20'habcde));
        prog_q.push_back(enc_auipc(5'd3, 20'h12345));
        prog_q.push_back(enc_addi(5'd4, 5'd0, 12'h100));
        prog_q.push_back(enc_sw(5'd1, 5'd4, 12'h000));
        prog_q.push_back(enc_sw(5'd2, 5'd4, 12'h004));
        prog_q.push_back(enc_sw(5'd3, 5'd4, 12'hff8));
        prog_q.push_back(enc_addi(5'd5, 5'd1, 12'hfff));
        prog_q.push_back(enc_sw(5'd5, 5'd4, 12'h00c));
        prog_q.push_back(enc_ebreak());
        load_program();
        reset_dut(1'b0);
        x1 = sext12(12'h123);
        x2 = {20'habcde, 12'h000};
        // auipc sits at byte address 8
        x3 = 32'd8 + {20'h12345, 12'h000};
        x4 = sext12(12'h100);
        expect_store(x4, x1);
        expect_store(x4 + 32'd4, x2);
        expect_store(x4 + sext12(12'hff8), x3);
        expect_store(x4 + 32'd12, x1 + sext12(12'hfff));
        finish_and_compare("arith", 1'b1, 32'h24);
    endtask

    task automatic test_jumps();
        prog_q.delete();
        prog_q.push_back(enc_addi(5'd4, 5'd0, 12'h200));
        prog_q.push_back(enc_jal(5'd1, 21'd8));
        prog_q.push_back(enc_sw(5'd0, 5'd4, 12'h000));
        prog_q.push_back(enc_sw(5'd1, 5'd4, 12'h004));
        // Odd base checks that bit 0 of the target is dropped
        prog_q.push_back(enc_addi(5'd6, 5'd0, 12'd33));
        prog_q.push_back(enc_jalr(5'd7, 5'd6, 12'd0));
        prog_q.push_back(enc_sw(5'd0, 5'd4, 12'h008));
        prog_q.push_back(enc_sw(5'd0, 5'd4, 12'h00c));
        prog_q.push_back(enc_sw(5'd7, 5'd4, 12'h010));
        prog_q.push_back(enc_ebreak());
        load_program();
        reset_dut(1'b0);
        expect_store(32'h204, 32'd8);
        expect_store(32'h210, 32'd24);
        finish_and_compare("jumps", 1'b1, 32'h24);
    endtask

    task automatic test_credits();
        prog_q.delete();
        prog_q.push_back(enc_addi(5'd4, 5'd0, 12'h400));
        for (int k = 0; k < 5; k++) begin
            prog_q.push_back(enc_addi(5'd1, 5'd0, 12'(16 + k)));
            prog_q.push_back(enc_sw(5'd1, 5'd4, 12'(4 * k)));
        end
        prog_q.push_back(enc_ebreak());
        load_program();
        reset_dut(1'b1);
        for (int k = 0; k < 5; k++) begin
            expect_store(32'h400 + word_t'(4 * k), word_t'(16 + k));
        end
        wait_stores(`STORE_CREDITS);
        settle(20);
        check_word("credits stalled count", word_t'(got_q.size()), word_t'(`STORE_CREDITS));
        check_bit("credits stalled halt_o", halt, 1'b0);
        hold_credits = 1'b0;
        wait_stores(5);
        finish_and_compare("credits", 1'b1, 32'h2c);
    endtask

    task automatic test_ebreak();
        prog_q.delete();
        prog_q.push_back(enc_addi(5'd4, 5'd0, 12'h500));
        prog_q.push_back(enc_addi(5'd1, 5'd0, 12'h055));
        prog_q.push_back(enc_sw(5'd1, 5'd4, 12'h000));
        prog_q.push_back(enc_ebreak());
        prog_q.push_back(enc_sw(5'd1, 5'd4, 12'h004));
        prog_q.push_back(enc_addi(5'd2, 5'd0, 12'h001));
        prog_q.push_back(enc_sw(5'd2, 5'd4, 12'h008));
        load_program();
        reset_dut(1'b0);
        expect_store(32'h500, 32'h55);
        finish_and_compare("ebreak", 1'b1, 32'h0c);
    endtask

    task automatic test_illegal();
        prog_q.delete();
        prog_q.push_back(enc_addi(5'd4, 5'd0, 12'h600));
        prog_q.push_back(enc_addi(5'd1, 5'd0, 12'h066));
        prog_q.push_back(enc_sw(5'd1, 5'd4, 12'h000));
        // custom-0 opcode lies outside the subset
        prog_q.push_back(32'h0000_000b);
        prog_q.push_back(enc_sw(5'd1, 5'd4, 12'h004));
        load_program();
        reset_dut(1'b0);
        expect_store(32'h600, 32'h66);
        finish_and_compare("illegal", 1'b0, 32'h0c);
    endtask

    task automatic test_random();
        logic [11:0] imm;
        word_t       sum;
        sum = '0;
        prog_q.delete();
        for (int k = 0; k < 20; k++) begin
            imm = 12'($urandom);
            sum = sum + sext12(imm);
            prog_q.push_back(enc_addi(5'd1, (k == 0) ? 5'd0 : 5'd1, imm));
        end
        prog_q.push_back(enc_addi(5'd4, 5'd0, 12'h300));
        prog_q.push_back(enc_sw(5'd1, 5'd4, 12'h000));
        prog_q.push_back(enc_ebreak());
        load_program();
        reset_dut(1'b0);
        expect_store(32'h300, sum);
        finish_and_compare("random", 1'b1, 32'h58);
    endtask

    initial begin
        void'($urandom(32'h8b7b_5bff));
        test_arith();
        test_jumps();
        test_credits();
        test_ebreak();
        test_illegal();
        test_random();
        $display("checks run %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
